/* rename.f */
+incdir+bench
verilog/rename_pkg.sv
verilog/rf_multi_write.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rename_unit.sv
bench/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module rename_tb -f rename.f -o rename_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "RESULT: PASS" "$LOG"; then
   echo "simulation passed"
   exit 0
fi

echo "pass message not found in $LOG"
exit 1

/* bench/rename_tests.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests for the rename unit
// reset map, allocation, bypass/WAW, exhaustion, back-pressure, random stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic reset_mapping();
   req_group_t req;
   rsp_group_t exp;
   compare_flag(out_valid, 1'b0, "out_valid after reset");
   for (int i = 0; i < 4; i++) begin
      req[0] = make_req(1'b1, 1'b0, '0, rand_reg(), rand_reg());  // lookups only
      req[1] = make_req(1'b1, 1'b0, '0, rand_reg(), rand_reg());
      send_group(req, exp);
      compare_tag(out_rsp[0].prs1, phys_tag_t'(req[0].rs1), "reset map rs1");
      compare_tag(out_rsp[1].prs2, phys_tag_t'(req[1].rs2), "reset map rs2");
   end
endtask

task automatic tag_allocation();
   req_group_t req;
   rsp_group_t exp;
   phys_tag_t  want;
   want   = phys_tag_t'(NUM_PHYS - NUM_FREE);  // first free tag after reset
   req[1] = '0;
   for (int i = 0; i < 3; i++) begin
      req[0] = make_req(1'b1, 1'b1, rand_dest(), rand_reg(), rand_reg());
      send_group(req, exp);
      compare_tag(out_rsp[0].prd, want, "in-order prd");
      want++;
   end
   req[0] = make_req(1'b1, 1'b1, '0, rand_reg(), rand_reg());     // x0 dest
   send_group(req, exp);
   compare_tag(out_rsp[0].prd, '0, "x0 prd");
   req[0] = make_req(1'b1, 1'b1, rand_dest(), rand_reg(), rand_reg());
   send_group(req, exp);
   compare_tag(out_rsp[0].prd, want, "prd after x0");     // head not consumed
endtask

task automatic group_bypass_waw();
   req_group_t req;
   rsp_group_t exp;
   arch_reg_t  rd;
   phys_tag_t  winner;
   rd     = rand_dest();
   req[0] = make_req(1'b1, 1'b1, rd, rand_reg(), rand_reg());
   req[1] = make_req(1'b1, 1'b1, rand_dest(), rd, rd);     // RAW on slot 0
   send_group(req, exp);
   compare_tag(out_rsp[1].prs1, exp[0].prd, "bypass rs1");
   compare_tag(out_rsp[1].prs2, exp[0].prd, "bypass rs2");
   req[0] = make_req(1'b1, 1'b1, rd, rand_reg(), rand_reg());
   req[1] = make_req(1'b1, 1'b1, rd, rand_reg(), rand_reg()); // same rd
   send_group(req, exp);
   compare_tag(out_rsp[1].old_prd, exp[0].prd, "WAW old_prd");
   winner = exp[1].prd;
   req[0] = make_req(1'b1, 1'b0, '0, rd, rd);
   req[1] = '0;
   send_group(req, exp);
   compare_tag(out_rsp[0].prs1, winner, "WAW survivor");
endtask

task automatic exhaust_and_recycle();
   req_group_t req;
   rsp_group_t exp;
   phys_tag_t  freed [2];
   apply_reset();
   for (int i = 0; i < NUM_FREE / 2; i++) begin
      req[0] = make_req(1'b1, 1'b1, rand_dest(), rand_reg(), rand_reg());
      req[1] = make_req(1'b1, 1'b1, rand_dest(), rand_reg(), rand_reg());
      send_group(req, exp);
      if (i == 0) begin
         freed[0] = exp[0].old_prd;
         freed[1] = exp[1].old_prd;
      end
   end
   @(negedge CLK);
   in_req   = req;
   in_valid = 1'b1;
   #1;
   compare_flag(in_ready, 1'b0, "in_ready with empty free list");
   @(negedge CLK);
   in_valid  = 1'b0;
   commit[0] = '{valid: 1'b1, tag: freed[0]};
   commit[1] = '{valid: 1'b1, tag: freed[1]};
   free_q.push_back(freed[0]);             // slot 0 first
   free_q.push_back(freed[1]);
   @(negedge CLK);
   commit = '0;
   send_group(req, exp);
   compare_tag(out_rsp[0].prd, freed[0], "recycled tag slot 0");
   compare_tag(out_rsp[1].prd, freed[1], "recycled tag slot 1");
endtask

task automatic hold_under_backpressure();
   req_group_t req;
   rsp_group_t held;
   rsp_group_t exp;
   apply_reset();
   req[0] = make_req(1'b1, 1'b1, rand_dest(), rand_reg(), rand_reg());
   req[1] = make_req(1'b1, 1'b1, rand_dest(), rand_reg(), rand_reg());
   @(negedge CLK);
   out_ready = 1'b0;
   send_group(req, held);
   for (int i = 0; i < 4; i++) begin
      @(negedge CLK);
      in_req   = req;                      // second group waits
      in_valid = 1'b1;
      #1;
      compare_flag(out_valid, 1'b1, "out_valid while stalled");
      compare_flag(in_ready, 1'b0, "in_ready while stalled");
      compare_rsp(out_rsp[0], held[0], "held slot 0");
      compare_rsp(out_rsp[1], held[1], "held slot 1");
   end
   @(negedge CLK);
   in_valid  = 1'b0;
   out_ready = 1'b1;                       // drain the held group
   send_group(req, exp);
endtask

task automatic random_stream();
   req_group_t             req;
   rsp_group_t             exp;
   rsp_group_t             done;
   rsp_group_t             pend [$];
   commit_t [RN_WIDTH-1:0] to_free;
   int                     sent;
   int                     got;
   int                     cycles;
   sent    = 0;
   got     = 0;
   cycles  = 0;
   to_free = '0;
   req     = random_group();
   while (got < 40) begin
      if (cycles == 2000) begin
         fail_now("timeout: random stream did not drain 40 groups");
      end
      @(negedge CLK);
      cycles++;
      in_req    = req;
      in_valid  = (sent < 40);
      out_ready = (lcg_next() % 32'd3) != 32'd0;
      commit    = to_free;                 // old tags of last transfer
      #1;
      to_free = '0;
      if (out_valid && out_ready) begin
         if (pend.size() == 0) begin
            fail_now("output valid with no group pending");
         end
         done = pend.pop_front();
         compare_rsp(out_rsp[0], done[0], "stream slot 0");
         compare_rsp(out_rsp[1], done[1], "stream slot 1");
         for (int s = 0; s < RN_WIDTH; s++) begin
            to_free[s].valid = done[s].prd != '0;
            to_free[s].tag   = done[s].old_prd;
         end
         got++;
      end
      if (in_valid && in_ready) begin
         predict_group(req, exp);          // pops before this edge's pushes
         pend.push_back(exp);
         sent++;
         req = random_group();
      end
      for (int s = 0; s < RN_WIDTH; s++) begin
         if (commit[s].valid) begin
            free_q.push_back(commit[s].tag);
         end
      end
   end
   @(negedge CLK);
   in_valid = 1'b0;
   commit   = '0;
endtask

/* bench/rename_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the two-wide rename unit
// clock, reset, DUT, LCG, reference RAT and free queue, compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rename_tb;

   import rename_pkg::*;

   typedef rename_req_t [RN_WIDTH-1:0] req_group_t;
   typedef rename_rsp_t [RN_WIDTH-1:0] rsp_group_t;

   localparam int WAIT_LIMIT = 64;         // cycles per handshake wait

   logic                       CLK = 1'b0;
   logic                       RST;
   req_group_t                 in_req;
   logic                       in_valid;
   logic                       in_ready;
   rsp_group_t                 out_rsp;
   logic                       out_valid;
   logic                       out_ready;
   commit_t [RN_WIDTH-1:0]     commit;

   logic [31:0] lcg_state;
   phys_tag_t   model_rat [NUM_ARCH];      // expected mapping
   phys_tag_t   free_q [$];                // expected free tags, FIFO order

   always #50 CLK = ~CLK;                  // 100 ns period

   rename_unit i_rename_unit (
      .CLK       (CLK),
      .RST       (RST),
      .in_req    (in_req),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_rsp   (out_rsp),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .commit    (commit)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic arch_reg_t rand_reg();
      return arch_reg_t'(lcg_next() >> 27);            // top bits, better spread
   endfunction

   function automatic arch_reg_t rand_dest();
      return arch_reg_t'(32'd1 + lcg_next() % 32'd31); // never x0
   endfunction

   function automatic rename_req_t make_req(input logic v, input logic we, input arch_reg_t rd,
                                            input arch_reg_t rs1, input arch_reg_t rs2);
      return '{valid: v, rd_we: we, rd: rd, rs1: rs1, rs2: rs2};
   endfunction

   function automatic req_group_t random_group();
      req_group_t g;
      for (int s = 0; s < RN_WIDTH; s++) begin
         g[s] = make_req((lcg_next() % 32'd8) != 32'd0, (lcg_next() % 32'd4) != 32'd0,
                         rand_reg(), rand_reg(), rand_reg());
      end
      return g;
   endfunction

   // slots in order, so slot 1 sees slot 0's rename
   task automatic predict_group(input req_group_t req, output rsp_group_t exp);
      for (int s = 0; s < RN_WIDTH; s++) begin
         exp[s] = '0;
         if (req[s].valid) begin
            exp[s].valid = 1'b1;
            exp[s].prs1  = model_rat[req[s].rs1];
            exp[s].prs2  = model_rat[req[s].rs2];
            if (req[s].rd_we && req[s].rd != '0) begin
               exp[s].old_prd     = model_rat[req[s].rd];
               exp[s].prd         = free_q.pop_front();
               model_rat[req[s].rd] = exp[s].prd;
            end
         end
      end
   endtask

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic compare_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_now($sformatf("** Error at %0t: %s got %b expected %b", $time, what, got, exp));
      end
   endtask

   task automatic compare_tag(input phys_tag_t got, input phys_tag_t exp, input string what);
      if (got !== exp) begin
         fail_now($sformatf("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic compare_rsp(input rename_rsp_t got, input rename_rsp_t exp, input string what);
      string msg;
      if (got !== exp) begin
         msg = $sformatf("** Error at %0t: %s got %0b/%0d/%0d/%0d/%0d", $time, what,
                         got.valid, got.prd, got.prs1, got.prs2, got.old_prd);
         msg = {msg, $sformatf(" expected %0b/%0d/%0d/%0d/%0d (valid/prd/prs1/prs2/old_prd)",
                               exp.valid, exp.prd, exp.prs1, exp.prs2, exp.old_prd)};
         fail_now(msg);
      end
   endtask

   task automatic apply_reset();
      @(negedge CLK);
      RST       = 1'b0;
      in_valid  = 1'b0;
      out_ready = 1'b1;
      commit    = '0;
      for (int r = 0; r < NUM_ARCH; r++) begin
         model_rat[r] = phys_tag_t'(r);    // identity map
      end
      free_q.delete();
      for (int t = NUM_PHYS - NUM_FREE; t < NUM_PHYS; t++) begin
         free_q.push_back(phys_tag_t'(t));
      end
      repeat (8) @(negedge CLK);
      RST = 1'b1;
   endtask

   // present a group, wait for acceptance, check the registered response
   task automatic send_group(input req_group_t req, output rsp_group_t exp);
      int waited;
      waited = 0;
      @(negedge CLK);
      in_req   = req;
      in_valid = 1'b1;
      #1;
      while (!in_ready) begin
         if (waited == WAIT_LIMIT) begin
            fail_now("timeout: in_ready stayed low while a group was offered");
         end
         @(negedge CLK);
         #1;
         waited++;
      end
      predict_group(req, exp);             // accepted at the coming edge
      @(negedge CLK);
      in_valid = 1'b0;
      #1;
      compare_flag(out_valid, 1'b1, "out_valid after accept");
      compare_rsp(out_rsp[0], exp[0], "slot 0");
      compare_rsp(out_rsp[1], exp[1], "slot 1");
   endtask

   `include "rename_tests.svh"

   initial begin
      lcg_state   = 32'h5f31ba6d;
      RST         = 1'b0;
      in_req      = '0;
      in_valid    = 1'b0;
      out_ready   = 1'b1;
      commit      = '0;
      apply_reset();
      reset_mapping();
      tag_allocation();
      group_bypass_waw();
      exhaust_and_recycle();
      hold_under_backpressure();
      random_stream();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/rename_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-wide integer rename stage, top level
// valid/ready handshake, free tag check, RAT update and output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rename_unit #(
   parameter int FL_DEPTH     = rename_pkg::NUM_FREE,
   parameter int FL_FIRST_TAG = rename_pkg::NUM_PHYS - rename_pkg::NUM_FREE
) (
   input  wire                                                   CLK,
   input  wire                                                   RST,
   input  wire  rename_pkg::rename_req_t [rename_pkg::RN_WIDTH-1:0] in_req,
   input  wire                                                   in_valid,
   output logic                                                  in_ready,
   output rename_pkg::rename_rsp_t       [rename_pkg::RN_WIDTH-1:0] out_rsp,
   output logic                                                  out_valid,
   input  wire                                                   out_ready,
   input  wire  rename_pkg::commit_t     [rename_pkg::RN_WIDTH-1:0] commit
);

   import rename_pkg::*;

   // arch reg r starts on tag r
   function automatic logic [NUM_ARCH*PHYS_AW-1:0] identity_map();
      logic [NUM_ARCH*PHYS_AW-1:0] v;
      for (int r = 0; r < NUM_ARCH; r++) begin
         v[r*PHYS_AW +: PHYS_AW] = PHYS_AW'(r);
      end
      return v;
   endfunction

   localparam int CW = $clog2(FL_DEPTH+1);
   localparam logic [NUM_ARCH*PHYS_AW-1:0] RAT_RESET = identity_map();

   phys_tag_t   [RN_WIDTH-1:0] head_tag;
   logic        [CW-1:0]       free_cnt;
   rename_rsp_t [RN_WIDTH-1:0] rsp;
   logic        [1:0]          rename_cnt;
   logic                       accept;
   logic        [1:0]          pop;

   // room downstream and enough free tags for this group
   assign in_ready = (!out_valid || out_ready) && (free_cnt >= CW'(rename_cnt));
   assign accept   = in_valid && in_ready;
   assign pop      = accept ? rename_cnt : 2'd0;

   map_table #(
      .DW         (PHYS_AW),
      .AW         (ARCH_AW),
      .NUM_WRITE  (2),
      .RST_VECTOR (RAT_RESET)
   ) i_map_table (
      .CLK        (CLK),
      .RST        (RST),
      .req        (in_req),
      .new_tag    (head_tag),
      .wr_en      (accept),
      .rsp        (rsp),
      .rename_cnt (rename_cnt)
   );

   free_list #(
      .DEPTH     (FL_DEPTH),
      .FIRST_TAG (FL_FIRST_TAG)
   ) i_free_list (
      .CLK      (CLK),
      .RST      (RST),
      .pop      (pop),
      .head_tag (head_tag),
      .count    (free_cnt),
      .push     (commit)         // always taken
   );

   // output stage, held while stalled
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         out_valid <= 1'b0;
      end else if (accept) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;      // drained, nothing new
      end
   end

   always_ff @(posedge CLK) begin
      if (accept) begin
         out_rsp <= rsp;         // payload only, valid bit above
      end
   end

endmodule

`default_nettype wire

/* verilog/map_table.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register alias table for a two-wide group
// source lookup, in-group bypass, tag assignment and WAW resolution
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module map_table #(
   parameter int DW        = 6,
   parameter int AW        = 5,
   parameter int NUM_WRITE = 2,
   parameter logic [(2**AW)*DW-1:0] RST_VECTOR = '0
) (
   input  wire                                     CLK,
   input  wire                                     RST,
   input  wire  rename_pkg::rename_req_t [1:0]     req,
   input  wire  rename_pkg::phys_tag_t   [1:0]     new_tag,    // free list heads
   input  wire                                     wr_en,      // group accepted
   output rename_pkg::rename_rsp_t       [1:0]     rsp,
   output logic [1:0]                              rename_cnt  // tags consumed
);

   import rename_pkg::*;

   logic [(2**AW)-1:0][DW-1:0]  rat;      // current mapping, all entries
   logic [NUM_WRITE-1:0]        rat_we;
   logic [NUM_WRITE-1:0][AW-1:0] rat_waddr;
   logic [NUM_WRITE-1:0][DW-1:0] rat_wdata;

   logic      ren0;
   logic      ren1;
   phys_tag_t tag0;
   phys_tag_t tag1;
   logic      hit_rs1;  // slot 1 src matches slot 0 dest
   logic      hit_rs2;
   logic      hit_rd;

   // x0 and non-writing slots do not rename
   assign ren0 = req[0].valid && req[0].rd_we && (req[0].rd != '0);
   assign ren1 = req[1].valid && req[1].rd_we && (req[1].rd != '0);

   assign tag0 = new_tag[0];
   assign tag1 = ren0 ? new_tag[1] : new_tag[0]; // next unused head

   assign rename_cnt = {1'b0, ren0} + {1'b0, ren1};

   assign hit_rs1 = ren0 && (req[1].rs1 == req[0].rd);
   assign hit_rs2 = ren0 && (req[1].rs2 == req[0].rd);
   assign hit_rd  = ren0 && (req[1].rd  == req[0].rd);

   always_comb begin
      rsp = '0;
      if (req[0].valid) begin
         rsp[0].valid   = 1'b1;
         rsp[0].prd     = ren0 ? tag0 : '0;
         rsp[0].prs1    = rat[req[0].rs1];
         rsp[0].prs2    = rat[req[0].rs2];
         rsp[0].old_prd = ren0 ? rat[req[0].rd] : '0;
      end
      if (req[1].valid) begin
         rsp[1].valid   = 1'b1;
         rsp[1].prd     = ren1 ? tag1 : '0;
         rsp[1].prs1    = hit_rs1 ? tag0 : rat[req[1].rs1]; // RAW within group
         rsp[1].prs2    = hit_rs2 ? tag0 : rat[req[1].rs2];
         if (ren1) begin
            rsp[1].old_prd = hit_rd ? tag0 : rat[req[1].rd]; // WAW, frees slot 0 tag
         end
      end
   end

   // port 1 above port 0, slot 1 mapping survives a shared rd
   assign rat_we[0]    = wr_en && ren0;
   assign rat_waddr[0] = req[0].rd;
   assign rat_wdata[0] = tag0;
   assign rat_we[1]    = wr_en && ren1;
   assign rat_waddr[1] = req[1].rd;
   assign rat_wdata[1] = tag1;

   rf_multi_write #(
      .DW         (DW),
      .AW         (AW),
      .NUM_WRITE  (NUM_WRITE),
      .RST_VECTOR (RST_VECTOR)
   ) i_rat (
      .CLK   (CLK),
      .RST   (RST),
      .we    (rat_we),
      .waddr (rat_waddr),
      .wdata (rat_wdata),
      .dout  (rat)
   );

endmodule

`default_nettype wire

/* verilog/free_list.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free physical tag list
// circular queue, two pops and two pushes per cycle, occupancy count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module free_list #(
   parameter int DEPTH     = 32,
   parameter int FIRST_TAG = 32
) (
   input  wire                                 CLK,
   input  wire                                 RST,
   input  wire  [1:0]                          pop,      // 0..2 tags taken
   output rename_pkg::phys_tag_t [1:0]         head_tag, // next two free tags
   output logic [$clog2(DEPTH+1)-1:0]          count,
   input  wire  rename_pkg::commit_t [1:0]     push
);

   import rename_pkg::*;

   localparam int PW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH+1);

   phys_tag_t        mem [DEPTH];
   logic [PW-1:0]    rd_ptr;
   logic [PW-1:0]    wr_ptr;
   logic [PW-1:0]    wr_ptr_1;  // slot for push[1]
   logic [1:0]       n_push;

   // pointer advance with wrap at DEPTH
   function automatic logic [PW-1:0] ptr_add(input logic [PW-1:0] p, input logic [1:0] n);
      logic [PW:0] s;
      s = {1'b0, p} + (PW+1)'(n);
      if (s >= (PW+1)'(DEPTH)) begin
         s = s - (PW+1)'(DEPTH);
      end
      return s[PW-1:0];
   endfunction

   assign n_push   = {1'b0, push[0].valid} + {1'b0, push[1].valid};
   assign wr_ptr_1 = ptr_add(wr_ptr, {1'b0, push[0].valid}); // packed behind slot 0

   assign head_tag[0] = mem[rd_ptr];
   assign head_tag[1] = mem[ptr_add(rd_ptr, 2'd1)];

   // tag storage, preloaded with FIRST_TAG upward
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= phys_tag_t'(FIRST_TAG + i);
         end
      end else begin
         if (push[0].valid) begin
            mem[wr_ptr] <= push[0].tag;
         end
         if (push[1].valid) begin
            mem[wr_ptr_1] <= push[1].tag;
         end
      end
   end

   // pointers and occupancy
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         rd_ptr <= '0;
         wr_ptr <= '0;                     // full, wr meets rd
         count  <= CW'(DEPTH);
      end else begin
         rd_ptr <= ptr_add(rd_ptr, pop);
         wr_ptr <= ptr_add(wr_ptr, n_push);
         count  <= count + CW'(n_push) - CW'(pop); // net change this cycle
      end
   end

endmodule

`default_nettype wire

/* verilog/rf_multi_write.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register array with several prioritized write ports
// every entry driven out in parallel, reset image given as a parameter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module rf_multi_write #(
   parameter int DW        = 8,
   parameter int AW        = 4,
   parameter int NUM_WRITE = 2,
   parameter logic [(2**AW)*DW-1:0] RST_VECTOR = '0
) (
   input  wire                                CLK,
   input  wire                                RST,
   input  wire  [NUM_WRITE-1:0]               we,
   input  wire  [NUM_WRITE-1:0][AW-1:0]       waddr,
   input  wire  [NUM_WRITE-1:0][DW-1:0]       wdata,
   output logic [(2**AW)-1:0][DW-1:0]         dout
);

   logic [DW-1:0] regs [2**AW]; // storage

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int j = 0; j < 2**AW; j++) begin
            regs[j] <= RST_VECTOR[j*DW +: DW]; // entry j from image slice j
         end
      end else begin
         // later port assigned last, so it wins on same address
         for (int p = 0; p < NUM_WRITE; p++) begin
            if (we[p]) begin
               regs[waddr[p]] <= wdata[p];
            end
         end
      end
   end

   // whole array visible at once
   always_comb begin
      for (int j = 0; j < 2**AW; j++) begin
         dout[j] = regs[j];
      end
   end

endmodule

`default_nettype wire

/* verilog/rename_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename stage package
// register and tag widths, table sizes, request/response/commit slot structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rename_pkg;

   localparam int ARCH_AW  = 5;                 // x0..x31
   localparam int PHYS_AW  = 6;                 // p0..p63
   localparam int NUM_ARCH = 1 << ARCH_AW;
   localparam int NUM_PHYS = 1 << PHYS_AW;
   localparam int NUM_FREE = NUM_PHYS - NUM_ARCH; // tags not mapped after reset
   localparam int RN_WIDTH = 2;                 // slots per group

   typedef logic [ARCH_AW-1:0] arch_reg_t;
   typedef logic [PHYS_AW-1:0] phys_tag_t;

   // one decoded instruction entering rename
   typedef struct packed {
      logic      valid;
      logic      rd_we;   // writes a destination
      arch_reg_t rd;
      arch_reg_t rs1;
      arch_reg_t rs2;
   } rename_req_t;

   // one renamed instruction leaving the stage
   typedef struct packed {
      logic      valid;
      phys_tag_t prd;     // new dest tag, 0 if not renamed
      phys_tag_t prs1;
      phys_tag_t prs2;
      phys_tag_t old_prd; // freed when this instr commits
   } rename_rsp_t;

   // tag returned by the commit side
   typedef struct packed {
      logic      valid;
      phys_tag_t tag;
   } commit_t;

endpackage

`default_nettype wire
